// ==== logic/rename_pkg.sv ====
// Sizes, instruction union, fetch slot, source record and queue entry types, back-branch decode
`default_nettype none

package rename_pkg;

	// ==============================
	// Sizes
	// ==============================

	// Architectural registers tracked by the source table
	localparam int AREGS = 32;
	// Depth of the circular issue queue
	localparam int QENTRIES = 8;
	// Opcode shared by all conditional branches
	localparam logic [5:0] OP_BRANCH = 6'h12;

	typedef logic [$clog2(AREGS)-1:0] reg_ndx_t;
	typedef logic [$clog2(QENTRIES)-1:0] que_ndx_t;
	typedef logic [QENTRIES-1:0] que_mask_t;

	// ==============================
	// Instruction word
	// ==============================

	// Register to register and immediate operations
	typedef struct packed {
		logic [5:0] opcode;
		reg_ndx_t rt;
		reg_ndx_t rs1;
		reg_ndx_t rs2;
		logic [10:0] imm;
	} alu_instr_t;

	// Compare and branch, the displacement is relative to the branch itself
	typedef struct packed {
		logic [5:0] opcode;
		reg_ndx_t rs1;
		reg_ndx_t rs2;
		logic signed [15:0] disp;
	} br_instr_t;

	// The same 32 bits seen through either decode
	typedef union packed {
		alu_instr_t alu;
		br_instr_t br;
	} instruction_t;

	// One slot of the fetch buffer as presented to dispatch
	typedef struct packed {
		logic v;
		instruction_t instr;
		reg_ndx_t rt;
		logic rfw;
		logic mem;
	} fetch_slot_t;

	// Table record, mem selects the memory result bus over the ALU bus
	typedef struct packed {
		logic pending;
		logic mem;
		que_ndx_t ndx;
	} reg_src_t;

	// Dispatch bookkeeping kept per queue entry
	typedef struct packed {
		logic v;
		reg_ndx_t tgt;
		logic rfw;
		logic mem;
	} iq_entry_t;

	// A branch with a negative displacement is taken as a loop back
	function automatic logic is_back_branch(instruction_t instr);
		return (instr.br.opcode == OP_BRANCH) && instr.br.disp[15];
	endfunction

endpackage

`default_nettype wire

// ==== logic/enqueue_ctrl.sv ====
// Dispatch control: slot acceptance, back-branch cut, retire gating and rebuild timing
`timescale 1ns/1ps
`default_nettype none

module enqueue_ctrl (
	input wire logic clk,
	input wire logic rst,
	input rename_pkg::fetch_slot_t fetch0,
	input rename_pkg::fetch_slot_t fetch1,
	input wire logic branchmiss,
	input wire logic retire,
	input wire logic tail0_free,
	input wire logic tail1_free,
	input wire logic head_valid,
	output logic enq0,
	output logic enq1,
	output logic enq0_slot_sel,
	output logic [1:0] enq_count,
	output logic did_branchback,
	output logic do_retire,
	output logic rebuild
);

	import rename_pkg::*;

	// Recovery spans the miss cycle and the rebuild cycle after it
	logic blocked;
	// Slot 0 holds a loop-back branch
	logic back0;

	assign blocked = branchmiss | rebuild;
	assign back0 = is_back_branch(fetch0.instr);

	// ==============================
	// Slot acceptance
	// ==============================

	// enq0 writes the tail0 entry, enq1 writes the tail1 entry with fetch1
	always_comb begin
		enq0 = 1'b0;
		enq1 = 1'b0;
		enq0_slot_sel = 1'b0;
		if (!blocked) begin
			case ({fetch0.v, fetch1.v})
			2'b01: begin
				// A lone slot 1 moves down into the tail0 position
				enq0 = tail0_free;
				enq0_slot_sel = 1'b1;
			end
			2'b10: begin
				enq0 = tail0_free;
			end
			2'b11: begin
				enq0 = tail0_free;
				// The pair is cut after a back branch so fetch can redirect
				enq1 = tail0_free && !back0 && tail1_free;
			end
			default: begin
				enq0 = 1'b0;
			end
			endcase
		end
	end

	// Fetch uses the count to know which slots to present again
	assign enq_count = {1'b0, enq0} + {1'b0, enq1};

	// Only an accepted slot 0 can report a back branch
	assign did_branchback = enq0 && !enq0_slot_sel && back0;

	// Retirement needs a valid head and waits out recovery
	assign do_retire = retire && head_valid && !blocked;

	// ==============================
	// Rebuild timing
	// ==============================

	// The table is rebuilt one cycle after the squash settles in the queue
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rebuild <= 1'b0;
		end else begin
			rebuild <= branchmiss;
		end
	end

endmodule

`default_nettype wire

// ==== logic/issue_queue.sv ====
// Circular issue queue: entry storage, head and tail pointers, enqueue, retire and squash
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
	input wire logic clk,
	input wire logic rst,
	input wire logic enq0,
	input wire logic enq1,
	input wire logic enq0_slot_sel,
	input rename_pkg::fetch_slot_t fetch0,
	input rename_pkg::fetch_slot_t fetch1,
	input wire logic do_retire,
	input wire logic branchmiss,
	input rename_pkg::que_ndx_t miss_ndx,
	output rename_pkg::iq_entry_t [rename_pkg::QENTRIES-1:0] iq,
	output rename_pkg::que_ndx_t head,
	output rename_pkg::que_ndx_t tail0,
	output rename_pkg::que_ndx_t tail1,
	output logic tail0_free,
	output logic tail1_free,
	output logic head_valid,
	output rename_pkg::que_mask_t q_valid,
	output logic q_full
);

	import rename_pkg::*;

	// Occupied entries, always a contiguous run starting at head
	que_mask_t vld;
	// Payload of each entry, its v field is taken from vld
	iq_entry_t [QENTRIES-1:0] payload;
	// Slot that lands in the tail0 entry
	fetch_slot_t slot0;
	// Entries younger than the surviving branch
	que_mask_t squash;
	// Distance of the surviving branch from head
	que_ndx_t miss_age;

	assign slot0 = enq0_slot_sel ? fetch1 : fetch0;
	assign tail1 = tail0 + que_ndx_t'(1);
	assign miss_age = miss_ndx - head;

	// Age is counted from head so the comparison survives wrap-around
	always_comb begin
		for (int i = 0; i < QENTRIES; i++) begin
			squash[i] = que_ndx_t'(que_ndx_t'(i) - head) > miss_age;
		end
	end

	// ==============================
	// Pointers and occupancy
	// ==============================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld <= '0;
			head <= '0;
			tail0 <= '0;
		end else if (branchmiss) begin
			// Everything after miss_ndx up to the tail is thrown away
			vld <= vld & ~squash;
			tail0 <= miss_ndx + que_ndx_t'(1);
		end else begin
			if (do_retire) begin
				vld[head] <= 1'b0;
				head <= head + que_ndx_t'(1);
			end
			// A free tail0 is never the valid head, so these cannot collide
			if (enq0) begin
				vld[tail0] <= 1'b1;
			end
			if (enq1) begin
				vld[tail1] <= 1'b1;
			end
			tail0 <= tail0 + que_ndx_t'(enq0) + que_ndx_t'(enq1);
		end
	end

	// Payload only changes where a slot is written
	always_ff @(posedge clk) begin
		if (enq0) begin
			payload[tail0].tgt <= slot0.rt;
			payload[tail0].rfw <= slot0.rfw;
			payload[tail0].mem <= slot0.mem;
		end
		if (enq1) begin
			payload[tail1].tgt <= fetch1.rt;
			payload[tail1].rfw <= fetch1.rfw;
			payload[tail1].mem <= fetch1.mem;
		end
	end

	// ==============================
	// Outputs
	// ==============================

	always_comb begin
		for (int i = 0; i < QENTRIES; i++) begin
			iq[i] = payload[i];
			iq[i].v = vld[i];
		end
	end

	assign tail0_free = !vld[tail0];
	assign tail1_free = !vld[tail1];
	assign head_valid = vld[head];
	assign q_valid = vld;
	assign q_full = &vld;

endmodule

`default_nettype wire

// ==== logic/latest_writer.sv ====
// Age-ordered search for the youngest queued writer of each target register
`timescale 1ns/1ps
`default_nettype none

module latest_writer (
	input rename_pkg::iq_entry_t [rename_pkg::QENTRIES-1:0] iq,
	input rename_pkg::que_ndx_t head,
	output rename_pkg::que_mask_t latest
);

	import rename_pkg::*;

	// Position of each entry counted from the oldest one
	que_ndx_t age [QENTRIES];
	// Entries that write a register at all
	que_mask_t writer;

	always_comb begin
		for (int i = 0; i < QENTRIES; i++) begin
			age[i] = que_ndx_t'(i) - head;
			writer[i] = iq[i].v && iq[i].rfw;
		end
	end

	// ==============================
	// Youngest writer search
	// ==============================

	// Valid entries form one run from head to the tail, so any valid entry
	// with a larger age lies between this one and the tail
	always_comb begin
		for (int i = 0; i < QENTRIES; i++) begin
			latest[i] = writer[i];
			for (int j = 0; j < QENTRIES; j++) begin
				// A younger writer of the same register takes the flag away
				if (writer[j] && (iq[j].tgt == iq[i].tgt) && (age[j] > age[i])) begin
					latest[i] = 1'b0;
				end
			end
		end
	end

	// Examples of the rule, with head at entry 6 and entries 6, 7 and 0 valid:
	// entry 0 is the youngest, so if 6 and 0 both write r5 only entry 0 is
	// flagged, while entry 7 writing r9 keeps its flag
	//
	// Entries that do not write a register are never flagged and never
	// clear the flag of an older entry

endmodule

`default_nettype wire

// ==== logic/reg_source_table.sv ====
// Per-register pending and source table with enqueue, retire, rebuild and lookup
`timescale 1ns/1ps
`default_nettype none

module reg_source_table (
	input wire logic clk,
	input wire logic rst,
	input wire logic enq0,
	input wire logic enq1,
	input wire logic enq0_slot_sel,
	input rename_pkg::fetch_slot_t fetch0,
	input rename_pkg::fetch_slot_t fetch1,
	input rename_pkg::que_ndx_t tail0,
	input rename_pkg::que_ndx_t tail1,
	input wire logic do_retire,
	input rename_pkg::que_ndx_t head,
	input wire logic rebuild,
	input rename_pkg::iq_entry_t [rename_pkg::QENTRIES-1:0] iq,
	input rename_pkg::que_mask_t latest,
	input rename_pkg::reg_ndx_t query_reg,
	output rename_pkg::reg_src_t query_src
);

	import rename_pkg::*;

	// One record per architectural register
	reg_src_t rsrc [AREGS];
	// Slot written into the tail0 entry this cycle
	fetch_slot_t slot0;
	// Both slots enqueue and name the same target
	logic same_tgt;

	assign slot0 = enq0_slot_sel ? fetch1 : fetch0;
	assign same_tgt = enq0 && enq1 && (fetch0.rt == fetch1.rt);

	// ==============================
	// Table update
	// ==============================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int r = 0; r < AREGS; r++) begin
				rsrc[r] <= '0;
			end
		end else if (rebuild) begin
			// Start from an empty table
			for (int r = 0; r < AREGS; r++) begin
				rsrc[r].pending <= 1'b0;
			end
			// Each register has at most one flagged entry, so writes never clash
			for (int i = 0; i < QENTRIES; i++) begin
				if (latest[i]) begin
					rsrc[iq[i].tgt] <= '{pending: 1'b1, mem: iq[i].mem, ndx: que_ndx_t'(i)};
				end
			end
		end else begin
			// The head still being latest means the record points at it
			if (do_retire && latest[head]) begin
				rsrc[iq[head].tgt].pending <= 1'b0;
			end
			// Enqueue writes come last so a new writer of the same register wins
			if (same_tgt) begin
				// Slot 1 is younger and owns the record whenever it writes
				if (fetch1.rfw) begin
					rsrc[fetch1.rt] <= '{pending: 1'b1, mem: fetch1.mem, ndx: tail1};
				end else if (fetch0.rfw) begin
					rsrc[fetch0.rt] <= '{pending: 1'b1, mem: fetch0.mem, ndx: tail0};
				end
			end else begin
				if (enq0 && slot0.rfw) begin
					rsrc[slot0.rt] <= '{pending: 1'b1, mem: slot0.mem, ndx: tail0};
				end
				if (enq1 && fetch1.rfw) begin
					rsrc[fetch1.rt] <= '{pending: 1'b1, mem: fetch1.mem, ndx: tail1};
				end
			end
		end
	end

	// Lookup port for operand source selection
	assign query_src = rsrc[query_reg];

endmodule

`default_nettype wire

// ==== logic/rename_top.sv ====
// Top level of the dispatch and rename tracking block
`timescale 1ns/1ps
`default_nettype none

module rename_top (
	input wire logic clk,
	input wire logic rst,
	input rename_pkg::fetch_slot_t fetch0,
	input rename_pkg::fetch_slot_t fetch1,
	input wire logic retire,
	input wire logic branchmiss,
	input rename_pkg::que_ndx_t miss_ndx,
	input rename_pkg::reg_ndx_t query_reg,
	output logic [1:0] enq_count,
	output logic did_branchback,
	output rename_pkg::reg_src_t query_src,
	output rename_pkg::que_mask_t q_valid,
	output logic q_full
);

	import rename_pkg::*;

	// Control to datapath
	logic enq0;
	logic enq1;
	logic enq0_slot_sel;
	logic do_retire;
	logic rebuild;

	// Queue state seen by control and the table
	logic tail0_free;
	logic tail1_free;
	logic head_valid;
	iq_entry_t [QENTRIES-1:0] iq;
	que_ndx_t head;
	que_ndx_t tail0;
	que_ndx_t tail1;
	que_mask_t latest;

	enqueue_ctrl u_ctrl (
		.clk, .rst, .fetch0, .fetch1, .branchmiss, .retire,
		.tail0_free, .tail1_free, .head_valid,
		.enq0, .enq1, .enq0_slot_sel, .enq_count, .did_branchback,
		.do_retire, .rebuild
	);

	issue_queue u_queue (
		.clk, .rst, .enq0, .enq1, .enq0_slot_sel, .fetch0, .fetch1,
		.do_retire, .branchmiss, .miss_ndx,
		.iq, .head, .tail0, .tail1, .tail0_free, .tail1_free, .head_valid,
		.q_valid, .q_full
	);

	latest_writer u_latest (.iq, .head, .latest);

	reg_source_table u_table (
		.clk, .rst, .enq0, .enq1, .enq0_slot_sel, .fetch0, .fetch1,
		.tail0, .tail1, .do_retire, .head, .rebuild, .iq, .latest,
		.query_reg, .query_src
	);

endmodule

`default_nettype wire

// ==== tb/rename_model.svh ====
// Reference model of queue and source table, LFSR source and fetch slot builder
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Model state is updated once per rising edge
iq_entry_t mq [QENTRIES];
que_ndx_t m_head;
que_ndx_t m_tail;
reg_src_t m_tab [AREGS];
logic m_rebuild;
// Expected slot acceptance for the current cycle
logic e0;
logic e1;
logic esel;
logic [31:0] lfsr_state = 32'h49bbc764;

// Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
function automatic logic [31:0] rand_bits(int n);
	logic [31:0] r;
	logic fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

// Loop back means branch opcode with a negative displacement
function automatic logic model_back(fetch_slot_t s);
	return s.instr.br.opcode == OP_BRANCH && $signed(s.instr.br.disp) < 0;
endfunction

// Targets stay in r0 to r7 so that writers collide often
function automatic fetch_slot_t make_slot(logic v, logic back);
	fetch_slot_t s;
	s.v = v;
	s.instr = rand_bits(32);
	s.rt = reg_ndx_t'(rand_bits(3));
	s.mem = 1'(rand_bits(1));
	if (back) begin
		s.instr.br.opcode = OP_BRANCH;
		s.instr.br.disp[15] = 1'b1;
		s.rfw = 1'b0;
	end else begin
		if (s.instr.alu.opcode == OP_BRANCH)
			s.instr.alu.opcode = OP_BRANCH ^ 6'h01;
		s.rfw = rand_bits(2) != 0;
	end
	return s;
endfunction

// The last writer seen on a walk from oldest to youngest owns its register
function automatic que_mask_t model_latest();
	int owner [AREGS];
	que_mask_t lat;
	int i;
	lat = '0;
	for (int r = 0; r < AREGS; r++)
		owner[r] = -1;
	for (int k = 0; k < QENTRIES; k++) begin
		i = (int'(m_head) + k) % QENTRIES;
		if (mq[i].v && mq[i].rfw)
			owner[mq[i].tgt] = i;
	end
	for (int r = 0; r < AREGS; r++)
		if (owner[r] >= 0)
			lat[owner[r]] = 1'b1;
	return lat;
endfunction

`endif

// ==== tb/rename_tb.sv ====
// Testbench for rename_top: clock, reset, watchdog, model driven stimulus and checks
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

	import rename_pkg::*;

	localparam int CLK_PERIOD = 100;
	// Cycle budget of each phase, summed below for the watchdog
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_CYCLES = 60;
	// Same target, retire, back branch, fill and branch miss cycles
	localparam int DIRECTED_CYCLES = 19;
	localparam int TEST_CYCLES = RESET_CYCLES + 2 * AREGS + RANDOM_CYCLES
		+ 2 * (QENTRIES + 2) + DIRECTED_CYCLES;
	localparam int MARGIN_CYCLES = 50;

	logic clk;
	logic rst;
	fetch_slot_t fetch0;
	fetch_slot_t fetch1;
	logic retire;
	logic branchmiss;
	que_ndx_t miss_ndx;
	reg_ndx_t query_reg;
	logic [1:0] enq_count;
	logic did_branchback;
	reg_src_t query_src;
	que_mask_t q_valid;
	logic q_full;
	string test_name;

	`include "rename_model.svh"

	rename_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog against a DUT or testbench that stops making progress
	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: the run did not finish within its cycle budget");
		$display("RESULT: FAIL");
		$fatal(1);
	end

	task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
		assert (exp === act) else begin
			$display("error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// Expected acceptance follows the free-entry rule and the back-branch cut
	task automatic model_accept(logic bm);
		logic free0;
		logic free1;
		free0 = !mq[m_tail].v;
		free1 = !mq[que_ndx_t'(m_tail + 1)].v;
		e0 = 1'b0;
		e1 = 1'b0;
		esel = 1'b0;
		if (!(bm || m_rebuild)) begin
			if (fetch0.v) begin
				e0 = free0;
				if (fetch1.v && free0 && !model_back(fetch0))
					e1 = free1;
			end else if (fetch1.v) begin
				e0 = free0;
				esel = 1'b1;
			end
		end
	endtask

	// Advance the model across one rising edge
	task automatic model_edge();
		que_mask_t lat;
		fetch_slot_t s0;
		que_ndx_t t1;
		que_ndx_t k;
		lat = model_latest();
		t1 = m_tail + que_ndx_t'(1);
		s0 = esel ? fetch1 : fetch0;
		if (branchmiss) begin
			// Walk from the entry after the kept one up to the tail
			k = miss_ndx + que_ndx_t'(1);
			while (k != m_tail) begin
				mq[k].v = 1'b0;
				k = k + que_ndx_t'(1);
			end
			m_tail = miss_ndx + que_ndx_t'(1);
		end else if (m_rebuild) begin
			for (int r = 0; r < AREGS; r++)
				m_tab[r].pending = 1'b0;
			for (int i = 0; i < QENTRIES; i++)
				if (lat[i])
					m_tab[mq[i].tgt] = '{pending: 1'b1, mem: mq[i].mem, ndx: que_ndx_t'(i)};
		end else begin
			if (retire && mq[m_head].v) begin
				if (lat[m_head])
					m_tab[mq[m_head].tgt].pending = 1'b0;
				mq[m_head].v = 1'b0;
				m_head = m_head + que_ndx_t'(1);
			end
			// Slot 1 owns a target shared by both taken slots whenever it writes
			if (e0 && e1 && fetch0.rt == fetch1.rt) begin
				if (fetch1.rfw)
					m_tab[fetch1.rt] = '{pending: 1'b1, mem: fetch1.mem, ndx: t1};
				else if (fetch0.rfw)
					m_tab[fetch0.rt] = '{pending: 1'b1, mem: fetch0.mem, ndx: m_tail};
			end else begin
				if (e0 && s0.rfw)
					m_tab[s0.rt] = '{pending: 1'b1, mem: s0.mem, ndx: m_tail};
				if (e1 && fetch1.rfw)
					m_tab[fetch1.rt] = '{pending: 1'b1, mem: fetch1.mem, ndx: t1};
			end
			if (e0)
				mq[m_tail] = '{v: 1'b1, tgt: s0.rt, rfw: s0.rfw, mem: s0.mem};
			if (e1)
				mq[t1] = '{v: 1'b1, tgt: fetch1.rt, rfw: fetch1.rfw, mem: fetch1.mem};
			m_tail = m_tail + que_ndx_t'(e0) + que_ndx_t'(e1);
		end
		m_rebuild = branchmiss;
	endtask

	// Drive on the rising edge, compare at the falling edge, then step the model
	task automatic run_cycle(fetch_slot_t f0, fetch_slot_t f1, logic ret, logic bm,
			que_ndx_t mndx, reg_ndx_t qr);
		que_mask_t mv;
		@(posedge clk);
		fetch0 <= f0;
		fetch1 <= f1;
		retire <= ret;
		branchmiss <= bm;
		miss_ndx <= mndx;
		query_reg <= qr;
		@(negedge clk);
		model_accept(bm);
		for (int i = 0; i < QENTRIES; i++)
			mv[i] = mq[i].v;
		check_val("enq_count", 32'(e0) + 32'(e1), 32'(enq_count));
		check_val("did_branchback", 32'(e0 && !esel && model_back(f0)), 32'(did_branchback));
		check_val("q_valid", 32'(mv), 32'(q_valid));
		check_val("q_full", 32'(&mv), 32'(q_full));
		check_val("query_src", 32'(m_tab[qr]), 32'(query_src));
		model_edge();
	endtask

	task automatic scan_table();
		for (int r = 0; r < AREGS; r++)
			run_cycle(make_slot(0, 0), make_slot(0, 0), 1'b0, 1'b0, '0, reg_ndx_t'(r));
	endtask

	task automatic drain_queue();
		for (int n = 0; n < QENTRIES + 2; n++)
			run_cycle(make_slot(0, 0), make_slot(0, 0), 1'b1, 1'b0, '0,
				reg_ndx_t'(rand_bits(3)));
	endtask

	task automatic fill_queue(int pairs);
		for (int n = 0; n < pairs; n++)
			run_cycle(make_slot(1, 0), make_slot(1, 0), 1'b0, 1'b0, '0,
				reg_ndx_t'(rand_bits(3)));
	endtask

	initial begin
		fetch0 <= '0;
		fetch1 <= '0;
		retire <= 1'b0;
		branchmiss <= 1'b0;
		miss_ndx <= '0;
		query_reg <= '0;
		rst <= 1'b1;
		for (int i = 0; i < QENTRIES; i++)
			mq[i] = '0;
		for (int r = 0; r < AREGS; r++)
			m_tab[r] = '0;
		m_head = '0;
		m_tail = '0;
		m_rebuild = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		test_name = "reset";
		scan_table();

		// Pairs with one target, first with slot 1 writing, then with only slot 0 writing
		test_name = "same_target";
		begin
			fetch_slot_t older;
			fetch_slot_t younger;
			older = make_slot(1, 0);
			younger = make_slot(1, 0);
			older.rfw = 1'b1;
			younger.rfw = 1'b1;
			younger.rt = older.rt;
			run_cycle(older, younger, 1'b0, 1'b0, '0, older.rt);
			younger.rfw = 1'b0;
			run_cycle(older, younger, 1'b0, 1'b0, '0, older.rt);
			// Two overtaken writers retire first and leave the register pending
			test_name = "retire_latest";
			repeat (3)
				run_cycle(make_slot(0, 0), make_slot(0, 0), 1'b1, 1'b0, '0, older.rt);
			run_cycle(make_slot(0, 0), make_slot(0, 0), 1'b0, 1'b0, '0, older.rt);
		end

		// Mixed pairs, lone slots and occasional retirement
		test_name = "random";
		for (int n = 0; n < RANDOM_CYCLES; n++)
			run_cycle(make_slot(rand_bits(2) != 0, rand_bits(3) == 0),
				make_slot(rand_bits(2) != 0, 0), rand_bits(2) == 0, 1'b0, '0,
				reg_ndx_t'(rand_bits(3)));
		drain_queue();

		test_name = "back_branch";
		begin
			fetch_slot_t bb;
			fetch_slot_t nx;
			bb = make_slot(1, 1);
			// The dropped slot 1 would overwrite the same record if it were taken
			nx = make_slot(1, 0);
			nx.rt = bb.rt;
			nx.rfw = 1'b1;
			run_cycle(bb, nx, 1'b0, 1'b0, '0, bb.rt);
			run_cycle(make_slot(0, 0), make_slot(0, 0), 1'b0, 1'b0, '0, bb.rt);
		end

		// Overfill so that later pairs see a full queue, then retire it all
		test_name = "fill_retire";
		fill_queue(6);
		drain_queue();

		// Keep the two oldest entries of six and rebuild from them
		test_name = "branchmiss";
		fill_queue(3);
		run_cycle(make_slot(1, 0), make_slot(1, 0), 1'b0, 1'b1, m_head + que_ndx_t'(1), '0);
		run_cycle(make_slot(1, 0), make_slot(1, 0), 1'b1, 1'b0, '0, '0);
		scan_table();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tb
logic/rename_pkg.sv
logic/enqueue_ctrl.sv
logic/issue_queue.sv
logic/latest_writer.sv
logic/reg_source_table.sv
logic/rename_top.sv
tb/rename_tb.sv

// ==== Makefile ====
# Verilator build and run for the rename testbench

VERILATOR ?= verilator
TOP ?= rename_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
